// File: source/div_sqrt_prep_defines.svh
`ifndef DIV_SQRT_PREP_DEFINES_SVH
`define DIV_SQRT_PREP_DEFINES_SVH

//////////////////////////////////////////////////
// Binary32 format
//////////////////////////////////////////////////

// Operand, exponent and fraction widths
`define C_OP        32
`define C_EXP       8
`define C_MANT      23

// Exponent bias
`define C_BIAS      127

// Special exponent codes
`define C_EXP_INF   8'hff
`define C_EXP_ZERO  8'h00

// Leading-one index, covers C_MANT+1 positions
`define C_LZ_W      5

// Rounding mode field
`define C_RM        3

`endif

// File: source/fp_format_pkg.sv
`include "div_sqrt_prep_defines.svh"

package fp_format_pkg;

   //////////////////////////////////////////////////
   // Operand classification
   //////////////////////////////////////////////////

   // Class of one IEEE-754 operand
   typedef enum logic [2:0]
   {
      CLASS_ZERO,
      CLASS_SUBNORM,
      CLASS_NORMAL,
      CLASS_INF,
      CLASS_NAN
   } op_class_e;

   //////////////////////////////////////////////////
   // Unpacked operand
   //////////////////////////////////////////////////

   // Operand after unpacking and normalization
   typedef struct packed
   {
      logic                      sign;
      // Two extra bits so subnormals can go below one
      logic signed [`C_EXP+1:0]  exponent;
      // Hidden bit sits in the MSB
      logic [`C_MANT:0]          mantissa;
      op_class_e                 op_class;
   } unpacked_op_t;

endpackage

// File: source/div_sqrt_op_pkg.sv
`include "div_sqrt_prep_defines.svh"

package div_sqrt_op_pkg;

   //////////////////////////////////////////////////
   // Operation and result codes
   //////////////////////////////////////////////////

   // Requested operation
   typedef enum logic
   {
      OP_DIV,
      OP_SQRT
   } div_sqrt_op_e;

   // Result decided ahead of the iteration
   typedef enum logic [1:0]
   {
      SPECIAL_NONE,
      SPECIAL_NAN,
      SPECIAL_INF,
      SPECIAL_ZERO
   } special_e;

   //////////////////////////////////////////////////
   // Request and job
   //////////////////////////////////////////////////

   // Incoming request, raw operand bits
   typedef struct packed
   {
      div_sqrt_op_e        op;
      logic [`C_OP-1:0]    operand_a;
      logic [`C_OP-1:0]    operand_b;
      logic [`C_RM-1:0]    rm;
   } prep_req_t;

   // Job for the mantissa iteration engine
   typedef struct packed
   {
      div_sqrt_op_e              op;
      logic                      sign;
      logic signed [`C_EXP+1:0]  exponent;
      // Dropped LSB of the halved sqrt exponent
      logic                      exp_odd;
      logic [`C_MANT:0]          mant_a;
      logic [`C_MANT:0]          mant_b;
      special_e                  special;
      logic                      invalid;
      logic                      div_by_zero;
      logic [`C_RM-1:0]          rm;
   } prep_job_t;

endpackage

// File: source/leading_one_detect.sv
`timescale 1ns/1ns

`include "div_sqrt_prep_defines.svh"

module leading_one_detect
(
   input  logic [`C_MANT:0]    vector,
   // Zeros above the first one, i.e. the normalization shift
   output logic [`C_LZ_W-1:0]  first_one_idx,
   output logic                no_ones
);

   // Set once a one has been seen
   logic found;

   //////////////////////////////////////////////////
   // Priority search from the MSB
   //////////////////////////////////////////////////

   always_comb
   begin
      found         = 1'b0;
      first_one_idx = '0;
      for (int i = `C_MANT; i >= 0; i--)
      begin
         // Only the topmost one counts
         if (vector[i] && !found)
         begin
            found         = 1'b1;
            first_one_idx = (`C_LZ_W)'(`C_MANT - i);
         end
      end
   end

   // Index stays zero for an empty vector
   assign no_ones = ~found;

endmodule

// File: source/operand_unpack.sv
`timescale 1ns/1ns

`include "div_sqrt_prep_defines.svh"

module operand_unpack
   import fp_format_pkg::*;
(
   input  logic [`C_OP-1:0]  operand,
   output unpacked_op_t      unpacked
);

   // Raw fields
   logic                      sign;
   logic [`C_EXP-1:0]         exp_raw;
   logic [`C_MANT-1:0]        frac;
   logic                      hidden;
   logic [`C_MANT:0]          mant_raw;

   // Leading-one search
   logic [`C_LZ_W-1:0]        lz_idx;
   logic                      mant_zero;

   // Normalized values
   logic [`C_MANT:0]          mant_norm;
   logic signed [`C_EXP+1:0]  exp_norm;

   // Field checks
   logic                      exp_zero;
   logic                      exp_ones;
   logic                      frac_zero;
   op_class_e                 op_class;

   //////////////////////////////////////////////////
   // Split the operand
   //////////////////////////////////////////////////

   assign sign     = operand[`C_OP-1];
   assign exp_raw  = operand[`C_OP-2:`C_MANT];
   assign frac     = operand[`C_MANT-1:0];

   // Hidden bit only for a nonzero exponent
   assign hidden   = |exp_raw;
   assign mant_raw = {hidden, frac};

   leading_one_detect lod
   (
      .vector        (mant_raw),
      .first_one_idx (lz_idx),
      .no_ones       (mant_zero)
   );

   //////////////////////////////////////////////////
   // Normalization
   //////////////////////////////////////////////////

   // Shift the first one up to the hidden position
   assign mant_norm = mant_raw << lz_idx;

   // Stored exponent minus shift, plus one for a subnormal
   // Subnormals then share the scale of exponent code one
   assign exp_norm  = $signed({2'b00, exp_raw})
                    - $signed({{(`C_EXP+2-`C_LZ_W){1'b0}}, lz_idx})
                    + $signed({{(`C_EXP+1){1'b0}}, |lz_idx});

   //////////////////////////////////////////////////
   // Classification
   //////////////////////////////////////////////////

   assign exp_zero  = (exp_raw == `C_EXP_ZERO);
   assign exp_ones  = (exp_raw == `C_EXP_INF);
   assign frac_zero = ~|frac;

   always_comb
   begin
      // No bit set anywhere means exponent and fraction are zero
      if (mant_zero)
         op_class = CLASS_ZERO;
      else if (exp_ones && frac_zero)
         op_class = CLASS_INF;
      else if (exp_ones)
         op_class = CLASS_NAN;
      else if (exp_zero)
         op_class = CLASS_SUBNORM;
      else
         op_class = CLASS_NORMAL;
   end

   assign unpacked.sign     = sign;
   assign unpacked.exponent = exp_norm;
   assign unpacked.mantissa = mant_norm;
   assign unpacked.op_class = op_class;

endmodule

// File: source/special_case_resolve.sv
`timescale 1ns/1ns

`include "div_sqrt_prep_defines.svh"

module special_case_resolve
   import fp_format_pkg::*;
   import div_sqrt_op_pkg::*;
(
   input  logic                Clk_CI,
   input  logic                Rst_RBI,
   input  div_sqrt_op_e        op,
   input  logic [`C_RM-1:0]    rm,
   input  unpacked_op_t        op_a,
   input  unpacked_op_t        op_b,
   input  logic                in_valid,
   output logic                in_ready,
   output logic                out_valid,
   input  logic                out_ready,
   output prep_job_t           out_job
);

   // Exponent bias at the signed exponent width
   localparam logic signed [`C_EXP+1:0] BIAS = (`C_EXP+2)'(`C_BIAS);

   // Operand classes
   logic a_zero, a_inf, a_nan;
   logic b_zero, b_inf, b_nan;

   // Exponent arithmetic
   logic signed [`C_EXP+1:0]  exp_div;
   logic signed [`C_EXP+1:0]  exp_unbiased;
   logic signed [`C_EXP+1:0]  exp_sqrt;

   // Handshake and job register
   logic       accept;
   logic       valid_q;
   prep_job_t  job_d;
   prep_job_t  job_q;

   assign a_zero = (op_a.op_class == CLASS_ZERO);
   assign a_inf  = (op_a.op_class == CLASS_INF);
   assign a_nan  = (op_a.op_class == CLASS_NAN);
   assign b_zero = (op_b.op_class == CLASS_ZERO);
   assign b_inf  = (op_b.op_class == CLASS_INF);
   assign b_nan  = (op_b.op_class == CLASS_NAN);

   //////////////////////////////////////////////////
   // Exponent estimate
   //////////////////////////////////////////////////

   assign exp_div      = op_a.exponent - op_b.exponent + BIAS;
   // Arithmetic shift halves toward minus infinity
   assign exp_unbiased = op_a.exponent - BIAS;
   assign exp_sqrt     = (exp_unbiased >>> 1) + BIAS;

   //////////////////////////////////////////////////
   // Next job
   //////////////////////////////////////////////////

   always_comb
   begin
      job_d             = '0;
      job_d.op          = op;
      job_d.rm          = rm;
      job_d.mant_a      = op_a.mantissa;
      job_d.mant_b      = op_b.mantissa;
      job_d.special     = SPECIAL_NONE;
      if (op == OP_DIV)
      begin
         job_d.sign     = op_a.sign ^ op_b.sign;
         job_d.exponent = exp_div;
         // Rule order matters here
         if (a_nan || b_nan || (a_zero && b_zero) || (a_inf && b_inf))
         begin
            job_d.special = SPECIAL_NAN;
            job_d.invalid = 1'b1;
         end
         else if (b_zero && !a_inf)
         begin
            // Finite nonzero over zero
            job_d.special     = SPECIAL_INF;
            job_d.div_by_zero = 1'b1;
         end
         else if (a_inf)
            job_d.special = SPECIAL_INF;
         else if (a_zero || b_inf)
            job_d.special = SPECIAL_ZERO;
      end
      else
      begin
         job_d.sign     = op_a.sign;
         job_d.exponent = exp_sqrt;
         job_d.exp_odd  = exp_unbiased[0];
         if (a_nan || (op_a.sign && !a_zero))
         begin
            job_d.special = SPECIAL_NAN;
            job_d.invalid = 1'b1;
         end
         // Signed zero keeps its sign
         else if (a_zero)
            job_d.special = SPECIAL_ZERO;
         else if (a_inf)
            job_d.special = SPECIAL_INF;
      end
      // NaN result is always positive
      if (job_d.special == SPECIAL_NAN)
         job_d.sign = 1'b0;
   end

   //////////////////////////////////////////////////
   // Output stage
   //////////////////////////////////////////////////

   // Free slot, or the held job leaves this cycle
   assign in_ready = ~valid_q | out_ready;
   assign accept   = in_valid & in_ready;

   always_ff @(posedge Clk_CI, negedge Rst_RBI)
   begin
      if (~Rst_RBI)
      begin
         valid_q <= 1'b0;
         job_q   <= '0;
      end
      else
      begin
         valid_q <= accept | (valid_q & ~out_ready);
         // Held under back-pressure
         if (accept)
            job_q <= job_d;
      end
   end

   assign out_valid = valid_q;
   assign out_job   = job_q;

endmodule

// File: source/div_sqrt_prep.sv
`timescale 1ns/1ns

`include "div_sqrt_prep_defines.svh"

module div_sqrt_prep
   import fp_format_pkg::*;
   import div_sqrt_op_pkg::*;
(
   input  logic        Clk_CI,
   input  logic        Rst_RBI,
   // Request side
   input  logic        in_valid,
   output logic        in_ready,
   input  prep_req_t   in_req,
   // Job side
   output logic        out_valid,
   input  logic        out_ready,
   output prep_job_t   out_job
);

   // Both operands after unpacking
   unpacked_op_t op_a;
   unpacked_op_t op_b;

   //////////////////////////////////////////////////
   // Operand unpack, side by side
   //////////////////////////////////////////////////

   operand_unpack unpack_a
   (
      .operand  (in_req.operand_a),
      .unpacked (op_a)
   );

   operand_unpack unpack_b
   (
      .operand  (in_req.operand_b),
      .unpacked (op_b)
   );

   //////////////////////////////////////////////////
   // Combine and register the job
   //////////////////////////////////////////////////

   special_case_resolve resolve
   (
      .Clk_CI    (Clk_CI),
      .Rst_RBI   (Rst_RBI),
      .op        (in_req.op),
      .rm        (in_req.rm),
      .op_a      (op_a),
      .op_b      (op_b),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_job   (out_job)
   );

endmodule

// File: verification/div_sqrt_prep_assert.sv
`timescale 1ns/1ns

module div_sqrt_prep_assert
   import div_sqrt_op_pkg::*;
(
   input  logic       Clk_CI,
   input  logic       Rst_RBI,
   input  logic       in_ready,
   input  logic       out_valid,
   input  logic       out_ready,
   input  prep_job_t  out_job
);

   // Failed property count
   int unsigned fail_count = 0;

   //////////////////////////////////////////////////
   // Handshake properties
   //////////////////////////////////////////////////

   // No job while reset is held
   reset_idle: assert property (@(posedge Clk_CI) !Rst_RBI |-> !out_valid)
   else
   begin
      $error("out_valid high during reset");
      fail_count++;
   end

   // Stalled job holds still
   job_held: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
      out_valid && !out_ready |=> out_valid && $stable(out_job))
   else
   begin
      $error("out_job changed or dropped under back-pressure");
      fail_count++;
   end

   // Ready when empty or draining
   ready_rule: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
      in_ready == (!out_valid || out_ready))
   else
   begin
      $error("in_ready does not follow out_valid and out_ready");
      fail_count++;
   end

endmodule

bind special_case_resolve div_sqrt_prep_assert assert_i
(
   .Clk_CI    (Clk_CI),
   .Rst_RBI   (Rst_RBI),
   .in_ready  (in_ready),
   .out_valid (out_valid),
   .out_ready (out_ready),
   .out_job   (out_job)
);

// File: verification/div_sqrt_prep_tb.sv
`timescale 1ns/1ns

`include "div_sqrt_prep_defines.svh"

module div_sqrt_prep_tb
   import fp_format_pkg::*;
   import div_sqrt_op_pkg::*;
();

   localparam int CLK_PERIOD   = 100;
   localparam int DRIVE_DLY    = 10;
   localparam int HANDSHAKE_TO = 1000;
   localparam int DRAIN_TO     = 5000;
   localparam int N_BACKPRESS  = 100;
   localparam int N_RANDOM     = 300;

   // DUT ports
   logic       Clk_CI;
   logic       Rst_RBI;
   logic       in_valid;
   logic       in_ready;
   prep_req_t  in_req;
   logic       out_valid;
   logic       out_ready;
   prep_job_t  out_job;

   // Pending requests and expected jobs
   prep_req_t  req_q[$];
   prep_job_t  exp_q[$];

   // One random state per stream
   logic [31:0] stim_state;
   logic [31:0] ready_state;
   logic        ready_random;
   // Holds out_ready low while set
   logic        ready_off;

   // Counters and their marks at each test start
   int unsigned error_count;
   int unsigned check_count;
   int unsigned in_count;
   int unsigned out_count;
   int unsigned test_count;
   int unsigned err_mark;
   int unsigned in_mark;
   int unsigned out_mark;

   div_sqrt_prep DUT
   (
      .Clk_CI    (Clk_CI),
      .Rst_RBI   (Rst_RBI),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_req    (in_req),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_job   (out_job)
   );

   initial
   begin
      Clk_CI = 1'b0;
      forever
         #(CLK_PERIOD/2) Clk_CI = ~Clk_CI;
   end

   //////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////

   // 32-bit xorshift step
   function automatic logic [31:0] next_rand(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic unpacked_op_t unpack_ref(input logic [`C_OP-1:0] x);
      unpacked_op_t      u;
      logic [`C_EXP-1:0] e;
      logic [`C_MANT:0]  m;
      int                shift;
      e     = x[`C_OP-2:`C_MANT];
      m     = {(e != 0), x[`C_MANT-1:0]};
      shift = 0;
      // Walk the first one up to the hidden position
      if (m != 0)
      begin
         while (!m[`C_MANT])
         begin
            m = m << 1;
            shift++;
         end
      end
      u.sign     = x[`C_OP-1];
      u.mantissa = m;
      u.exponent = (`C_EXP+2)'(int'(e) - shift + ((shift != 0) ? 1 : 0));
      if (e == 0 && x[`C_MANT-1:0] == 0)
         u.op_class = CLASS_ZERO;
      else if (e == 8'hff)
         u.op_class = (x[`C_MANT-1:0] == 0) ? CLASS_INF : CLASS_NAN;
      else if (e == 0)
         u.op_class = CLASS_SUBNORM;
      else
         u.op_class = CLASS_NORMAL;
      return u;
   endfunction

   function automatic prep_job_t model_job(input prep_req_t req);
      prep_job_t    j;
      unpacked_op_t a;
      unpacked_op_t b;
      int           ea;
      int           eb;
      int           u;
      int           h;
      logic         zero_a, inf_a, nan_a, fin_a;
      logic         zero_b, inf_b, nan_b;
      a      = unpack_ref(req.operand_a);
      b      = unpack_ref(req.operand_b);
      ea     = $signed(a.exponent);
      eb     = $signed(b.exponent);
      zero_a = (a.op_class == CLASS_ZERO);
      inf_a  = (a.op_class == CLASS_INF);
      nan_a  = (a.op_class == CLASS_NAN);
      fin_a  = !inf_a && !nan_a;
      zero_b = (b.op_class == CLASS_ZERO);
      inf_b  = (b.op_class == CLASS_INF);
      nan_b  = (b.op_class == CLASS_NAN);
      j        = '0;
      j.op     = req.op;
      j.rm     = req.rm;
      j.mant_a = a.mantissa;
      j.mant_b = b.mantissa;
      if (req.op == OP_DIV)
      begin
         j.sign     = a.sign ^ b.sign;
         j.exponent = (`C_EXP+2)'(ea - eb + `C_BIAS);
         if (nan_a || nan_b || (zero_a && zero_b) || (inf_a && inf_b))
         begin
            j.special = SPECIAL_NAN;
            j.invalid = 1'b1;
         end
         else if (zero_b && fin_a)
         begin
            j.special     = SPECIAL_INF;
            j.div_by_zero = 1'b1;
         end
         else if (inf_a)
            j.special = SPECIAL_INF;
         else if (zero_a || inf_b)
            j.special = SPECIAL_ZERO;
      end
      else
      begin
         // Floor of half the unbiased exponent
         u          = ea - `C_BIAS;
         h          = (u >= 0) ? u / 2 : -((1 - u) / 2);
         j.sign     = a.sign;
         j.exponent = (`C_EXP+2)'(h + `C_BIAS);
         j.exp_odd  = (u % 2 != 0);
         if (nan_a || (a.sign && !zero_a))
         begin
            j.special = SPECIAL_NAN;
            j.invalid = 1'b1;
         end
         else if (zero_a)
            j.special = SPECIAL_ZERO;
         else if (inf_a)
            j.special = SPECIAL_INF;
      end
      if (j.special == SPECIAL_NAN)
         j.sign = 1'b0;
      return j;
   endfunction

   // Random operand biased toward zero exponent and inf/NaN codes
   function automatic logic [31:0] shape_operand(input logic [31:0] r, input logic [2:0] sel);
      if (sel == 3'd0)
         return {r[31], 8'h00, r[22:0] >> r[26:23]};
      else if (sel == 3'd1)
         return {r[31], 8'hff, r[5] ? r[22:0] : 23'h0};
      else
         return r;
   endfunction

   //////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////

   task automatic check_field(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      check_count++;
      assert (got === exp)
      else
      begin
         $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
         error_count++;
      end
   endtask

   task automatic check_job(input prep_job_t got, input prep_job_t exp);
      check_field("out_job.op", got.op, exp.op);
      check_field("out_job.sign", got.sign, exp.sign);
      check_field("out_job.exponent", got.exponent, exp.exponent);
      check_field("out_job.exp_odd", got.exp_odd, exp.exp_odd);
      check_field("out_job.mant_a", got.mant_a, exp.mant_a);
      check_field("out_job.mant_b", got.mant_b, exp.mant_b);
      check_field("out_job.special", got.special, exp.special);
      check_field("out_job.invalid", got.invalid, exp.invalid);
      check_field("out_job.div_by_zero", got.div_by_zero, exp.div_by_zero);
      check_field("out_job.rm", got.rm, exp.rm);
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout while waiting for %s", what);
      $display("=== FAIL ===");
      $finish;
   endtask

   // Expected job at each input transfer sampled mid-cycle
   always @(negedge Clk_CI)
   begin
      if (Rst_RBI && in_valid && in_ready)
      begin
         exp_q.push_back(model_job(in_req));
         in_count++;
      end
   end

   // Compare at each output transfer
   always @(negedge Clk_CI)
   begin
      if (Rst_RBI && out_valid && out_ready)
      begin
         out_count++;
         assert (exp_q.size() != 0)
            check_job(out_job, exp_q.pop_front());
         else
         begin
            $display("A job left the DUT with no request pending");
            error_count++;
         end
      end
   end

   //////////////////////////////////////////////////
   // Drivers
   //////////////////////////////////////////////////

   // Entered and left just after a rising edge
   task automatic drive_req(input prep_req_t req);
      int   cycles;
      logic done;
      in_req   = req;
      in_valid = 1'b1;
      cycles   = 0;
      done     = 1'b0;
      while (!done && cycles < HANDSHAKE_TO)
      begin
         @(negedge Clk_CI);
         done = in_ready;
         @(posedge Clk_CI);
         #DRIVE_DLY;
         cycles++;
      end
      if (!done)
         report_timeout("the DUT to accept a request");
      else
         in_valid = 1'b0;
   endtask

   initial
   begin
      forever
      begin
         @(posedge Clk_CI);
         #DRIVE_DLY;
         while (req_q.size() > 0)
            drive_req(req_q.pop_front());
      end
   end

   // Output back-pressure
   initial
   begin
      forever
      begin
         @(posedge Clk_CI);
         #DRIVE_DLY;
         if (ready_off)
            out_ready = 1'b0;
         else if (ready_random)
         begin
            ready_state = next_rand(ready_state);
            out_ready   = ready_state[7];
         end
         else
            out_ready = 1'b1;
      end
   end

   task automatic add_req(input div_sqrt_op_e op, input logic [31:0] a,
                          input logic [31:0] b, input logic [2:0] rm);
      prep_req_t req;
      req.op        = op;
      req.operand_a = a;
      req.operand_b = b;
      req.rm        = rm;
      req_q.push_back(req);
   endtask

   task automatic add_random_req();
      logic [31:0] r_ctl;
      logic [31:0] r_a;
      logic [31:0] r_b;
      stim_state = next_rand(stim_state);
      r_ctl      = stim_state;
      stim_state = next_rand(stim_state);
      r_a        = stim_state;
      stim_state = next_rand(stim_state);
      r_b        = stim_state;
      add_req(div_sqrt_op_e'(r_ctl[0]), shape_operand(r_a, r_ctl[6:4]),
              shape_operand(r_b, r_ctl[10:8]), r_ctl[3:1]);
   endtask

   // Wait until nothing is queued or in flight
   task automatic wait_idle();
      int   cycles;
      logic idle;
      cycles = 0;
      idle   = 1'b0;
      while (!idle && cycles < DRAIN_TO)
      begin
         @(negedge Clk_CI);
         idle = (req_q.size() == 0) && !in_valid && !out_valid && (exp_q.size() == 0);
         cycles++;
      end
      if (!idle)
         report_timeout("the DUT to drain all jobs");
   endtask

   task automatic finish_test(input string name);
      int unsigned errs;
      // Every accepted request delivered once
      assert (in_count - in_mark == out_count - out_mark)
      else
      begin
         $display("%0d requests were accepted but %0d jobs came out",
                  in_count - in_mark, out_count - out_mark);
         error_count++;
      end
      errs = error_count - err_mark;
      test_count++;
      $display("Test %0d %s: %0d jobs, %0d errors", test_count, name,
               out_count - out_mark, errs);
      err_mark = error_count;
      in_mark  = in_count;
      out_mark = out_count;
   endtask

   //////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////

   initial
   begin : main
      logic [31:0] specials [8];
      int unsigned total_errors;
      Rst_RBI      = 1'b0;
      in_valid     = 1'b0;
      in_req       = '0;
      out_ready    = 1'b0;
      ready_random = 1'b0;
      ready_off    = 1'b1;
      stim_state   = 32'd12367;
      ready_state  = next_rand(32'd12367);
      error_count  = 0;
      check_count  = 0;
      in_count     = 0;
      out_count    = 0;
      test_count   = 0;
      err_mark     = 0;
      in_mark      = 0;
      out_mark     = 0;
      // +0, -0, +inf, -inf, NaN, 3.0, -3.0, subnormal
      specials = '{32'h00000000, 32'h80000000, 32'h7f800000, 32'hff800000,
                   32'h7fc00000, 32'h40400000, 32'hc0400000, 32'h00000010};
      repeat (5) @(posedge Clk_CI);
      #DRIVE_DLY;
      Rst_RBI = 1'b1;

      // Empty stage with out_ready low
      @(negedge Clk_CI);
      check_field("out_valid", out_valid, 1'b0);
      check_field("in_ready", in_ready, 1'b1);
      check_job(out_job, '0);
      ready_off = 1'b0;
      finish_test("reset state");

      add_req(OP_DIV, 32'h3f800000, 32'h3f800000, 3'd0);
      add_req(OP_DIV, 32'h40c00000, 32'h3fc00000, 3'd1);
      add_req(OP_DIV, 32'hc0600000, 32'h40000000, 3'd2);
      add_req(OP_DIV, 32'h7f000000, 32'h00800000, 3'd3);
      add_req(OP_SQRT, 32'h40800000, 32'h00000000, 3'd4);
      add_req(OP_SQRT, 32'h40000000, 32'h00000000, 3'd0);
      add_req(OP_SQRT, 32'h3e800000, 32'h00000000, 3'd1);
      add_req(OP_SQRT, 32'h3f000000, 32'h00000000, 3'd2);
      wait_idle();
      finish_test("normal operands");

      // Subnormals in both slots
      add_req(OP_DIV, 32'h00000001, 32'h3f800000, 3'd0);
      add_req(OP_DIV, 32'h3f800000, 32'h00400000, 3'd1);
      add_req(OP_DIV, 32'h007fffff, 32'h80000003, 3'd2);
      add_req(OP_SQRT, 32'h00000001, 32'h00000000, 3'd3);
      add_req(OP_SQRT, 32'h00200000, 32'h00000000, 3'd4);
      wait_idle();
      finish_test("subnormal operands");

      for (int i = 0; i < 8; i++)
      begin
         for (int k = 0; k < 8; k++)
            add_req(OP_DIV, specials[i], specials[k], 3'(k));
      end
      for (int i = 0; i < 8; i++)
         add_req(OP_SQRT, specials[i], 32'h3f800000, 3'(i));
      wait_idle();
      finish_test("special cases");

      ready_random = 1'b1;
      repeat (N_BACKPRESS) add_random_req();
      wait_idle();
      ready_random = 1'b0;
      finish_test("back-pressure");

      repeat (N_RANDOM) add_random_req();
      wait_idle();
      finish_test("random streaming");

      total_errors = error_count + DUT.resolve.assert_i.fail_count;
      $display("Tests: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
               test_count, check_count, error_count, DUT.resolve.assert_i.fail_count);
      if (total_errors == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

// File: div_sqrt_prep.f
+incdir+source
source/fp_format_pkg.sv
source/div_sqrt_op_pkg.sv
source/leading_one_detect.sv
source/operand_unpack.sv
source/special_case_resolve.sv
source/div_sqrt_prep.sv
verification/div_sqrt_prep_assert.sv
verification/div_sqrt_prep_tb.sv

// File: Bender.yml
package:
  name: div_sqrt_prep

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/fp_format_pkg.sv
      - source/div_sqrt_op_pkg.sv
      - source/leading_one_detect.sv
      - source/operand_unpack.sv
      - source/special_case_resolve.sv
      - source/div_sqrt_prep.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/div_sqrt_prep_assert.sv
      - verification/div_sqrt_prep_tb.sv
